// File: hw/sdb_entry.sv
//========================================
// top level of the stride detection buffer entry
//========================================
`timescale 1ns/1ps

module sdb_entry
  import sdb_pkg::*;
(
  input  logic     pfu_sdb_entry_clk,
  input  logic     cpurst_b,
  input  logic     create,
  input  pc_t      create_pc,
  input  logic     create_type_ld,
  input  logic     ready_grnt,
  input  logic     pop_all_part_vld,
  input  logic     l2_st_pref_en,
  input  logic     wa_cancel,
  input  logic     ld_da_pfu_pf_inst_vld,
  input  logic     st_da_pfu_pf_inst_vld,
  input  logic     ld_da_pfu_act_dp_vld,
  input  pc_t      ld_da_ldfifo_pc,
  input  pc_t      st_da_pc,
  input  va_t      ld_da_ppfu_va,
  input  va_t      st_da_ppfu_va,
  input  logic     ld_da_pfu_evict_cnt_vld,
  input  logic     st_da_pfu_evict_cnt_vld,
  input  timeout_t sdb_timeout_cnt_val,
  output logic     entry_vld,
  output pc_t      entry_pc,
  output logic     entry_type_ld,
  output logic     entry_ready,
  output logic     entry_evict,
  output logic     hit_pc_new,
  output stride_t  stride,
  output logic     stride_neg
);

  logic sel_inst_vld;
  va_t  sel_va;
  logic hit_pc;
  logic pf_inst_vld;
  logic info_vld;
  logic normal_stride;

  //========================================
  // input side
  //========================================
  sdb_pipe_select u_pipe_select (
    .entry_vld             (entry_vld),
    .entry_pc              (entry_pc),
    .entry_type_ld         (entry_type_ld),
    .ld_da_pfu_pf_inst_vld (ld_da_pfu_pf_inst_vld),
    .st_da_pfu_pf_inst_vld (st_da_pfu_pf_inst_vld),
    .ld_da_pfu_act_dp_vld  (ld_da_pfu_act_dp_vld),
    .ld_da_ldfifo_pc       (ld_da_ldfifo_pc),
    .st_da_pc              (st_da_pc),
    .ld_da_ppfu_va         (ld_da_ppfu_va),
    .st_da_ppfu_va         (st_da_ppfu_va),
    .sel_inst_vld          (sel_inst_vld),
    .sel_va                (sel_va),
    .hit_pc                (hit_pc),
    .pf_inst_vld           (pf_inst_vld),
    .hit_pc_new            (hit_pc_new)
  );

  //========================================
  // stride comparator
  //========================================
  sdb_stride_cmp u_stride_cmp (
    .pfu_sdb_entry_clk (pfu_sdb_entry_clk),
    .cpurst_b          (cpurst_b),
    .create            (create),
    .pf_inst_vld       (pf_inst_vld),
    .sel_va            (sel_va),
    .info_vld          (info_vld),
    .normal_stride     (normal_stride),
    .stride            (stride),
    .stride_neg        (stride_neg)
  );

  //========================================
  // output side
  //========================================
  sdb_entry_ctrl u_entry_ctrl (
    .pfu_sdb_entry_clk       (pfu_sdb_entry_clk),
    .cpurst_b                (cpurst_b),
    .create                  (create),
    .create_pc               (create_pc),
    .create_type_ld          (create_type_ld),
    .ready_grnt              (ready_grnt),
    .pop_all_part_vld        (pop_all_part_vld),
    .l2_st_pref_en           (l2_st_pref_en),
    .wa_cancel               (wa_cancel),
    .pf_inst_vld             (pf_inst_vld),
    .hit_pc                  (hit_pc),
    .sel_inst_vld            (sel_inst_vld),
    .ld_da_pfu_evict_cnt_vld (ld_da_pfu_evict_cnt_vld),
    .st_da_pfu_evict_cnt_vld (st_da_pfu_evict_cnt_vld),
    .sdb_timeout_cnt_val     (sdb_timeout_cnt_val),
    .info_vld                (info_vld),
    .normal_stride           (normal_stride),
    .entry_vld               (entry_vld),
    .entry_pc                (entry_pc),
    .entry_type_ld           (entry_type_ld),
    .entry_ready             (entry_ready),
    .entry_evict             (entry_evict)
  );

endmodule

// File: hw/sdb_entry_ctrl.sv
//========================================
// entry state, timeout, ready, evict, pop
//========================================
`timescale 1ns/1ps

module sdb_entry_ctrl
  import sdb_pkg::*;
(
  input  logic     pfu_sdb_entry_clk,
  input  logic     cpurst_b,
  input  logic     create,
  input  pc_t      create_pc,
  input  logic     create_type_ld,
  input  logic     ready_grnt,
  input  logic     pop_all_part_vld,
  input  logic     l2_st_pref_en,
  input  logic     wa_cancel,
  input  logic     pf_inst_vld,
  input  logic     hit_pc,
  input  logic     sel_inst_vld,
  input  logic     ld_da_pfu_evict_cnt_vld,
  input  logic     st_da_pfu_evict_cnt_vld,
  input  timeout_t sdb_timeout_cnt_val,
  input  logic     info_vld,
  input  logic     normal_stride,
  output logic     entry_vld,
  output pc_t      entry_pc,
  output logic     entry_type_ld,
  output logic     entry_ready,
  output logic     entry_evict
);

  timeout_t timeout_cnt;
  logic     timeout_full;
  logic     evict_cnt_vld;
  logic     ready_set;
  logic     evict_set;
  logic     pop_st;
  logic     pop_bad_stride;
  logic     pop_vld;

  //========================================
  // pop and set conditions
  //========================================
  assign evict_cnt_vld = ld_da_pfu_evict_cnt_vld || st_da_pfu_evict_cnt_vld;
  assign timeout_full  = (timeout_cnt == sdb_timeout_cnt_val);

  assign ready_set = entry_vld && info_vld && normal_stride;

  // another pc keeps using the pipe while this one stays idle
  assign evict_set = entry_vld
                     && !entry_ready
                     && sel_inst_vld
                     && timeout_full
                     && !hit_pc;

  // store prefetch off or cancelled
  assign pop_st = entry_vld
                  && !entry_type_ld
                  && (!l2_st_pref_en || wa_cancel);

  // stride not equal or crossing a page
  assign pop_bad_stride = entry_vld && info_vld && !normal_stride;

  assign pop_vld = ready_grnt
                   || pop_bad_stride
                   || pop_st
                   || pop_all_part_vld;

  //========================================
  // entry registers
  //========================================
  always_ff @(posedge pfu_sdb_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      entry_vld <= 1'b0;
    else if (pop_vld)
      entry_vld <= 1'b0;
    else if (create)
      entry_vld <= 1'b1;
  end

  always_ff @(posedge pfu_sdb_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      entry_pc      <= '0;
      entry_type_ld <= 1'b0;
    end
    else if (create)
    begin
      entry_pc      <= create_pc;
      entry_type_ld <= create_type_ld;
    end
  end

  // timeout counter saturates at the programmed value
  always_ff @(posedge pfu_sdb_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      timeout_cnt <= '0;
    else if (create || pf_inst_vld)
      timeout_cnt <= '0;
    else if (evict_cnt_vld && !timeout_full)
      timeout_cnt <= timeout_cnt + timeout_t'(1);
  end

  always_ff @(posedge pfu_sdb_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      entry_ready <= 1'b0;
    else if (create || pop_vld)
      entry_ready <= 1'b0;
    else if (ready_set)
      entry_ready <= 1'b1;
  end

  always_ff @(posedge pfu_sdb_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      entry_evict <= 1'b0;
    else if (create || pop_vld || pf_inst_vld)
      entry_evict <= 1'b0;
    else if (evict_set)
      entry_evict <= 1'b1;
  end

endmodule

// File: hw/sdb_pipe_select.sv
//========================================
// pipe info select and pc hit detection
//========================================
`timescale 1ns/1ps

module sdb_pipe_select
  import sdb_pkg::*;
(
  input  logic entry_vld,
  input  pc_t  entry_pc,
  input  logic entry_type_ld,
  input  logic ld_da_pfu_pf_inst_vld,
  input  logic st_da_pfu_pf_inst_vld,
  input  logic ld_da_pfu_act_dp_vld,
  input  pc_t  ld_da_ldfifo_pc,
  input  pc_t  st_da_pc,
  input  va_t  ld_da_ppfu_va,
  input  va_t  st_da_ppfu_va,
  output logic sel_inst_vld,
  output va_t  sel_va,
  output logic hit_pc,
  output logic pf_inst_vld,
  output logic hit_pc_new
);

  pc_t sel_pc;

  //========================================
  // pipe select
  //========================================
  // load entries watch the load pipe, store entries the store pipe
  assign sel_inst_vld = entry_type_ld
                        ? ld_da_pfu_pf_inst_vld
                        : st_da_pfu_pf_inst_vld;

  assign sel_pc = entry_type_ld
                  ? ld_da_ldfifo_pc
                  : st_da_pc;

  assign sel_va = entry_type_ld
                  ? ld_da_ppfu_va
                  : st_da_ppfu_va;

  //========================================
  // pc hit
  //========================================
  assign hit_pc = entry_vld
                  && (sel_pc == entry_pc);

  // a hit that the comparator records
  assign pf_inst_vld = hit_pc
                       && sel_inst_vld;

  // allocator uses this to skip creating a duplicate entry
  assign hit_pc_new = hit_pc
                      && !(entry_type_ld ^ ld_da_pfu_act_dp_vld);

endmodule

// File: hw/sdb_pkg.sv
//========================================
// widths and types shared by the stride
// detection buffer entry
//========================================
package sdb_pkg;

  //========================================
  // widths
  //========================================
  // compared part of the load/store pc
  localparam int PC_LEN     = 15;
  // virtual address from the da stage
  localparam int VA_WIDTH   = 40;
  localparam int TIMEOUT_BW = 8;
  // reported stride in two's complement
  localparam int STRIDE_BW  = 11;
  // in-page offset bits for 4 KiB pages
  localparam int PAGE_BW    = 12;

  //========================================
  // types
  //========================================
  typedef logic [PC_LEN-1:0]            pc_t;
  typedef logic [VA_WIDTH-1:0]          va_t;
  typedef logic [TIMEOUT_BW-1:0]        timeout_t;
  typedef logic signed [STRIDE_BW-1:0]  stride_t;

endpackage

// File: hw/sdb_stride_cmp.sv
//========================================
// address record and stride verdict
//========================================
`timescale 1ns/1ps

module sdb_stride_cmp
  import sdb_pkg::*;
(
  input  logic    pfu_sdb_entry_clk,
  input  logic    cpurst_b,
  input  logic    create,
  input  logic    pf_inst_vld,
  input  va_t     sel_va,
  output logic    info_vld,
  output logic    normal_stride,
  output stride_t stride,
  output logic    stride_neg
);

  // hits recorded so far, up to 2
  logic [1:0]              hit_cnt;
  logic                    rec_en;
  va_t                     last_va;
  logic signed [VA_WIDTH:0] delta1;
  logic                    same_page1;
  logic signed [VA_WIDTH:0] cur_delta;
  logic                    page_match;
  logic                    delta_eq;
  logic                    delta_nz;
  logic                    delta_in_range;
  logic                    verdict;

  //========================================
  // delta and page compare
  //========================================
  // record freezes once the verdict is out
  assign rec_en = pf_inst_vld && !info_vld;

  assign cur_delta = $signed({1'b0, sel_va}) - $signed({1'b0, last_va});

  assign page_match = (sel_va[VA_WIDTH-1:PAGE_BW] == last_va[VA_WIDTH-1:PAGE_BW]);

  assign delta_eq = (cur_delta == delta1);
  assign delta_nz = |delta1;

  // upper bits must be a pure sign extension of the stride
  assign delta_in_range = (&delta1[VA_WIDTH:STRIDE_BW-1])
                          || !(|delta1[VA_WIDTH:STRIDE_BW-1]);

  // same_page1 covers addr0/addr1 and page_match addr1/addr2
  assign verdict = delta_eq
                   && delta_nz
                   && delta_in_range
                   && same_page1
                   && page_match;

  //========================================
  // record
  //========================================
  always_ff @(posedge pfu_sdb_entry_clk)
  begin
    if (rec_en)
    begin
      last_va <= sel_va;
      // second hit fixes the reference delta
      if (hit_cnt == 2'd1)
      begin
        delta1     <= cur_delta;
        same_page1 <= page_match;
      end
    end
  end

  //========================================
  // hit count and verdict
  //========================================
  always_ff @(posedge pfu_sdb_entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      hit_cnt       <= 2'd0;
      info_vld      <= 1'b0;
      normal_stride <= 1'b0;
      stride        <= '0;
      stride_neg    <= 1'b0;
    end
    else if (create)
    begin
      hit_cnt       <= 2'd0;
      info_vld      <= 1'b0;
      normal_stride <= 1'b0;
    end
    else if (rec_en)
    begin
      if (hit_cnt == 2'd2)
      begin
        // third hit
        info_vld      <= 1'b1;
        normal_stride <= verdict;
        stride        <= delta1[STRIDE_BW-1:0];
        stride_neg    <= delta1[VA_WIDTH];
      end
      else
      begin
        hit_cnt <= hit_cnt + 2'd1;
      end
    end
  end

endmodule

// File: sources.f
hw/sdb_pkg.sv
hw/sdb_pipe_select.sv
hw/sdb_stride_cmp.sv
hw/sdb_entry_ctrl.sv
hw/sdb_entry.sv
verification/sdb_entry_tb.sv

// File: verification/sdb_entry_tb.sv
//========================================
// sdb entry testbench and stride reference
//========================================
`timescale 1ns/1ps

module sdb_entry_tb
  import sdb_pkg::*;
();

  // cycle budget for reset, 8 regular runs, 2 irregular runs and the rest
  localparam int RUN_CYCLES      = 4 + 8 * 6 + 2 * 7;
  localparam int OTHER_CYCLES    = 12 + 8 + 2 * 10;
  localparam int WATCHDOG_CYCLES = RUN_CYCLES + OTHER_CYCLES + 100;

  logic     pfu_sdb_entry_clk;
  logic     cpurst_b;
  logic     create;
  pc_t      create_pc;
  logic     create_type_ld;
  logic     ready_grnt;
  logic     pop_all_part_vld;
  logic     l2_st_pref_en;
  logic     wa_cancel;
  logic     ld_da_pfu_pf_inst_vld;
  logic     st_da_pfu_pf_inst_vld;
  logic     ld_da_pfu_act_dp_vld;
  pc_t      ld_da_ldfifo_pc;
  pc_t      st_da_pc;
  va_t      ld_da_ppfu_va;
  va_t      st_da_ppfu_va;
  logic     ld_da_pfu_evict_cnt_vld;
  logic     st_da_pfu_evict_cnt_vld;
  timeout_t sdb_timeout_cnt_val;
  logic     entry_vld;
  pc_t      entry_pc;
  logic     entry_type_ld;
  logic     entry_ready;
  logic     entry_evict;
  logic     hit_pc_new;
  stride_t  stride;
  logic     stride_neg;
  integer   seed;
  integer   i;
  integer   s;

  sdb_entry uut (.*);

  initial
  begin
    pfu_sdb_entry_clk = 1'b0;
    forever #50 pfu_sdb_entry_clk = ~pfu_sdb_entry_clk;
  end

  //========================================
  // reference and compare
  //========================================
  // returns {normal, sign, stride}
  function automatic logic [STRIDE_BW+1:0] ref_stride(input va_t a0, input va_t a1,
                                                      input va_t a2);
    longint x0;
    longint x1;
    longint x2;
    longint d1;
    longint d2;
    logic   normal;
    x0 = a0;
    x1 = a1;
    x2 = a2;
    d1 = x1 - x0;
    d2 = x2 - x1;
    normal = (d1 == d2) && (d1 != 0) && (d1 >= -1024) && (d1 <= 1023)
             && (a0[VA_WIDTH-1:PAGE_BW] == a1[VA_WIDTH-1:PAGE_BW])
             && (a1[VA_WIDTH-1:PAGE_BW] == a2[VA_WIDTH-1:PAGE_BW]);
    return {normal, d1 < 0, d1[STRIDE_BW-1:0]};
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_stride(input string name, input stride_t exp, input stride_t act);
    if (act !== exp)
      abort_run($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_pc(input string name, input pc_t exp, input pc_t act);
    if (act !== exp)
      abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
  endtask

  //========================================
  // stimulus helpers
  //========================================
  task automatic step();
    @(posedge pfu_sdb_entry_clk);
    #5;
  endtask

  task automatic create_entry(input string name, input pc_t pc, input logic ld);
    create = 1'b1;
    create_pc = pc;
    create_type_ld = ld;
    step();
    create = 1'b0;
    check_bit({name, " vld"}, 1'b1, entry_vld);
    check_pc({name, " pc"}, pc, entry_pc);
    check_bit({name, " type"}, ld, entry_type_ld);
    check_bit({name, " ready"}, 1'b0, entry_ready);
  endtask

  task automatic drive_hit(input pc_t pc, input va_t va, input logic ld);
    ld_da_pfu_pf_inst_vld = ld;
    st_da_pfu_pf_inst_vld = !ld;
    // other pipe carries the inverted pc and address
    ld_da_ldfifo_pc = ld ? pc : ~pc;
    st_da_pc = ld ? ~pc : pc;
    ld_da_ppfu_va = ld ? va : ~va;
    st_da_ppfu_va = ld ? ~va : va;
    step();
    ld_da_pfu_pf_inst_vld = 1'b0;
    st_da_pfu_pf_inst_vld = 1'b0;
  endtask

  task automatic pop_with_all(input string name);
    pop_all_part_vld = 1'b1;
    step();
    pop_all_part_vld = 1'b0;
    check_bit({name, " vld after pop all"}, 1'b0, entry_vld);
  endtask

  //========================================
  // test cases
  //========================================
  task automatic stride_sequence(input string name, input pc_t pc, input va_t a0,
                                 input va_t a1, input va_t a2);
    logic [STRIDE_BW+1:0] exp;
    exp = ref_stride(a0, a1, a2);
    create_entry(name, pc, 1'b1);
    drive_hit(pc, a0, 1'b1);
    drive_hit(pc, a1, 1'b1);
    drive_hit(pc, a2, 1'b1);
    // verdict just registered
    check_bit({name, " ready early"}, 1'b0, entry_ready);
    check_bit({name, " vld at verdict"}, 1'b1, entry_vld);
    step();
    check_bit({name, " ready"}, exp[STRIDE_BW+1], entry_ready);
    check_bit({name, " vld"}, exp[STRIDE_BW+1], entry_vld);
    if (exp[STRIDE_BW+1])
    begin
      check_stride({name, " stride"}, exp[STRIDE_BW-1:0], stride);
      check_bit({name, " stride_neg"}, exp[STRIDE_BW], stride_neg);
      ready_grnt = 1'b1;
      step();
      ready_grnt = 1'b0;
      check_bit({name, " vld after grant"}, 1'b0, entry_vld);
      check_bit({name, " ready after grant"}, 1'b0, entry_ready);
    end
    else
    begin
      repeat (2)
      begin
        step();
        check_bit({name, " ready stays low"}, 1'b0, entry_ready);
      end
    end
  endtask

  // base mid page keeps three accesses of up to 1024 bytes apart in one page
  task automatic random_page_stride(input string name, input integer st, input logic skew);
    logic [63:0] rnd;
    longint      b;
    rnd = {$random(seed), $random(seed)};
    b = {rnd[VA_WIDTH-1:PAGE_BW], 12'h800};
    stride_sequence(name, rnd[62:48], b, b + st, b + 2 * st + (skew ? 8 : 0));
  endtask

  task automatic timeout_evict(input pc_t pc, input timeout_t n);
    pc_t other_pc;
    other_pc = pc;
    other_pc[0] = ~pc[0];
    sdb_timeout_cnt_val = n;
    create_entry("timeout create", pc, 1'b1);
    ld_da_pfu_evict_cnt_vld = 1'b1;
    repeat (n - 1) step();
    ld_da_pfu_evict_cnt_vld = 1'b0;
    // another pc uses the load pipe one count short of the limit
    ld_da_pfu_pf_inst_vld = 1'b1;
    ld_da_ldfifo_pc = other_pc;
    step();
    ld_da_pfu_pf_inst_vld = 1'b0;
    check_bit("evict before timeout", 1'b0, entry_evict);
    ld_da_pfu_evict_cnt_vld = 1'b1;
    step();
    ld_da_pfu_evict_cnt_vld = 1'b0;
    check_bit("evict before miss", 1'b0, entry_evict);
    ld_da_pfu_pf_inst_vld = 1'b1;
    step();
    ld_da_pfu_pf_inst_vld = 1'b0;
    check_bit("evict after timeout miss", 1'b1, entry_evict);
    drive_hit(pc, 40'h12_3456_7000, 1'b1);
    check_bit("evict cleared by hit", 1'b0, entry_evict);
    pop_with_all("timeout");
    sdb_timeout_cnt_val = 8'hff;
  endtask

  task automatic store_pops(input pc_t pc);
    l2_st_pref_en = 1'b0;
    create_entry("store pref off", pc, 1'b0);
    step();
    check_bit("store pref off pop", 1'b0, entry_vld);
    l2_st_pref_en = 1'b1;
    wa_cancel = 1'b1;
    create_entry("store cancel", pc, 1'b0);
    step();
    check_bit("store cancel pop", 1'b0, entry_vld);
    wa_cancel = 1'b0;
    create_entry("load pop all", pc, 1'b1);
    pop_with_all("load");
  endtask

  task automatic hit_new_probe(input pc_t pc, input logic ld);
    integer r;
    integer k;
    pc_t    probe;
    logic   exp;
    create_entry("hit_pc_new create", pc, ld);
    for (k = 0; k < 8; k++)
    begin
      r = $random(seed);
      probe = r[0] ? pc : pc ^ {r[PC_LEN-1:1], 1'b1};
      ld_da_pfu_act_dp_vld = r[16];
      ld_da_ldfifo_pc = ld ? probe : ~probe;
      st_da_pc = ld ? ~probe : probe;
      exp = (probe == pc) && (r[16] == ld);
      #1;
      check_bit($sformatf("hit_pc_new type %b probe %0d", ld, k), exp, hit_pc_new);
      step();
    end
    ld_da_pfu_act_dp_vld = 1'b0;
    pop_with_all("hit_pc_new");
  endtask

  //========================================
  // main sequence
  //========================================
  initial
  begin
    seed = 32'he0b8_a4f1;
    cpurst_b = 1'b0;
    create = 1'b0;
    create_pc = '0;
    create_type_ld = 1'b0;
    ready_grnt = 1'b0;
    pop_all_part_vld = 1'b0;
    l2_st_pref_en = 1'b1;
    wa_cancel = 1'b0;
    ld_da_pfu_pf_inst_vld = 1'b0;
    st_da_pfu_pf_inst_vld = 1'b0;
    ld_da_pfu_act_dp_vld = 1'b0;
    ld_da_ldfifo_pc = '0;
    st_da_pc = '0;
    ld_da_ppfu_va = '0;
    st_da_ppfu_va = '0;
    ld_da_pfu_evict_cnt_vld = 1'b0;
    st_da_pfu_evict_cnt_vld = 1'b0;
    sdb_timeout_cnt_val = 8'hff;
    repeat (4) @(posedge pfu_sdb_entry_clk);
    #5;
    cpurst_b = 1'b1;
    check_bit("reset vld", 1'b0, entry_vld);
    check_bit("reset ready", 1'b0, entry_ready);
    check_bit("reset evict", 1'b0, entry_evict);
    check_pc("reset pc", '0, entry_pc);
    for (i = 0; i < 6; i++)
    begin
      s = $random(seed) % 1023;
      if (s == 0)
        s = 64;
      random_page_stride($sformatf("regular %0d stride %0d", i, s), s, 1'b0);
    end
    // range edges
    random_page_stride("regular min stride", -1024, 1'b0);
    random_page_stride("regular max stride", 1023, 1'b0);
    random_page_stride("unequal deltas", 96, 1'b1);
    stride_sequence("page crossing", 15'h2a5, 40'h3c_0000_0ff0, 40'h3c_0000_1010,
                    40'h3c_0000_1030);
    timeout_evict(15'h1b3c, 8'd5);
    store_pops(15'h0777);
    hit_new_probe(15'h4d21, 1'b1);
    hit_new_probe(15'h4d21, 1'b0);
    $display("Result: PASSED");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge pfu_sdb_entry_clk);
    abort_run("watchdog expired, the run hung before all tests finished");
  end

endmodule
